// ==== bench/fx3_loopback_assertions.sv ====
`timescale 1ns/1ps

module fx3_loopback_assertions (
    input logic usb_clk,
    input logic reset_,
    input logic slrd_n,
    input logic sloe_n,
    input logic slwr_n,
    input logic push,
    input logic pop,
    input logic full,
    input logic empty
);

    // fx3 only drives the bus with sloe low
    a_rd_needs_oe: assert property (@(posedge usb_clk) disable iff (!reset_)
        !slrd_n |-> !sloe_n)
        else $error("slrd low while sloe high");

    // bus direction is exclusive
    a_no_rd_wr: assert property (@(posedge usb_clk) disable iff (!reset_)
        !(!slrd_n && !slwr_n))
        else $error("slrd and slwr low together");

    a_no_push_full: assert property (@(posedge usb_clk) disable iff (!reset_)
        !(push && full))
        else $error("push into full fifo");

    a_no_pop_empty: assert property (@(posedge usb_clk) disable iff (!reset_)
        !(pop && empty))
        else $error("pop from empty fifo");

endmodule

// strobe rules on the pin side, fifo ports tied quiet
bind slave_fifo_port fx3_loopback_assertions i_port_asrt (
    .usb_clk (usb_clk),
    .reset_  (reset_),
    .slrd_n  (slrd_n_o),
    .sloe_n  (sloe_n_o),
    .slwr_n  (slwr_n_o),
    .push    (1'b0),
    .pop     (1'b0),
    .full    (1'b0),
    .empty   (1'b0)
);

// fifo rules, strobes tied inactive
bind loop_fifo fx3_loopback_assertions i_fifo_asrt (
    .usb_clk (usb_clk),
    .reset_  (reset_),
    .slrd_n  (1'b1),
    .sloe_n  (1'b1),
    .slwr_n  (1'b1),
    .push    (push_i),
    .pop     (pop_i),
    .full    (full_o),
    .empty   (empty_o)
);

// ==== bench/tb_fx3_loopback.sv ====
`timescale 1ns/1ps

module tb_fx3_loopback;

    localparam int WAIT_CYCLES = 2000;
    // eight bursts of 2000 cycles at 100 ns
    localparam int WATCHDOG_NS = 8 * 2000 * 100;

    logic                       usb_clk;
    logic                       reset_;
    logic                       flaga_i;
    logic                       flagc_i;
    logic                       flagd_i;
    logic [fx3_pkg::DATA_W-1:0] fdata_i;
    logic [fx3_pkg::DATA_W-1:0] fdata_o;
    logic                       fdata_oe_o;
    logic                       slcs_n_o;
    logic                       slrd_n_o;
    logic                       sloe_n_o;
    logic                       slwr_n_o;
    logic [1:0]                 fifo_addr_o;

    // fx3 model state
    logic [fx3_pkg::DATA_W-1:0] src_q[$];
    logic [fx3_pkg::DATA_W-1:0] wr_data_q[$];
    int                         rd_count;
    bit                         serve_pend1;
    bit                         serve_pend2;
    bit                         flaga_random;
    bit                         flaga_hist1;
    bit                         flaga_hist2;

    // bookkeeping
    string                      cur_test;
    int                         err_count;
    int                         tests_run;
    int                         tests_failed;

    fx3_loopback_top i_dut (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flaga_i     (flaga_i),
        .flagc_i     (flagc_i),
        .flagd_i     (flagd_i),
        .fdata_i     (fdata_i),
        .fdata_o     (fdata_o),
        .fdata_oe_o  (fdata_oe_o),
        .slcs_n_o    (slcs_n_o),
        .slrd_n_o    (slrd_n_o),
        .sloe_n_o    (sloe_n_o),
        .slwr_n_o    (slwr_n_o),
        .fifo_addr_o (fifo_addr_o)
    );

    always #50 usb_clk = ~usb_clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: %s expected %h actual %h", cur_test, name, exp, act);
            err_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", cur_test, msg);
        err_count++;
    endtask

    // fx3 model, everything seen at the falling edge where the pins are stable
    always @(negedge usb_clk) begin
        if (reset_ && !slrd_n_o) begin
            rd_count++;
            check("read addr", 32'(fx3_pkg::ADDR_OUT), 32'(fifo_addr_o));
            // fx3 ignores strobes without chip select
            check("read slcs_n", 32'd0, 32'(slcs_n_o));
        end
        if (reset_ && !slwr_n_o && fdata_oe_o) begin
            wr_data_q.push_back(fdata_o);
            check("write addr", 32'(fx3_pkg::ADDR_IN), 32'(fifo_addr_o));
            check("write slcs_n", 32'd0, 32'(slcs_n_o));
            // flaga low two falling edges back means in-fifo was full
            if (!flaga_hist2) begin
                report_error("write issued one cycle after FLAGA was sampled low");
            end
        end
        // word lands READ_LATENCY edges after fx3 samples slrd low
        if (serve_pend2) begin
            if (src_q.size() > 0) begin
                fdata_i = src_q.pop_front();
            end else begin
                report_error("master read more words than the model holds");
            end
        end
        serve_pend2 = serve_pend1;
        serve_pend1 = reset_ && !slrd_n_o;
        flaga_hist2 = flaga_hist1;
        if (flaga_random) begin
            flaga_i = 1'($urandom);
        end else begin
            flaga_i = 1'b1;
        end
        flaga_hist1 = flaga_i;
    end

    task automatic check_idle_levels(input string tag);
        check({tag, " slcs_n"}, 32'd1, 32'(slcs_n_o));
        check({tag, " slrd_n"}, 32'd1, 32'(slrd_n_o));
        check({tag, " sloe_n"}, 32'd1, 32'(sloe_n_o));
        check({tag, " slwr_n"}, 32'd1, 32'(slwr_n_o));
        check({tag, " fdata_oe"}, 32'd0, 32'(fdata_oe_o));
        check({tag, " addr"}, 32'(fx3_pkg::ADDR_IDLE), 32'(fifo_addr_o));
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        tests_run++;
    endtask

    task automatic finish_test(input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, err_count - errs_before);
            tests_failed++;
        end
    endtask

    task automatic test_reset_levels();
        int errs;
        errs = err_count;
        start_test("reset_levels");
        repeat (2) @(negedge usb_clk);
        check_idle_levels("in reset");
        repeat (2) @(negedge usb_clk);
        reset_ = 1'b1;
        repeat (2) @(negedge usb_clk);
        check_idle_levels("after reset");
        finish_test(errs);
    endtask

    task automatic test_one_flag_only();
        int errs;
        errs = err_count;
        start_test("one_flag_only");
        for (int pass = 0; pass < 2; pass++) begin
            @(negedge usb_clk);
            flagc_i = (pass == 0);
            flagd_i = (pass != 0);
            repeat (50) begin
                @(negedge usb_clk);
                check("one flag slcs_n", 32'd1, 32'(slcs_n_o));
                check("one flag slrd_n", 32'd1, 32'(slrd_n_o));
            end
        end
        @(negedge usb_clk);
        flagc_i = 1'b0;
        flagd_i = 1'b0;
        check("one flag reads", 32'd0, 32'(rd_count));
        finish_test(errs);
    endtask

    // one full read, turnaround and write burst
    task automatic run_burst(input string name, input bit rnd_data, input bit rnd_flaga,
                             input logic [fx3_pkg::DATA_W-1:0] base);
        logic [fx3_pkg::DATA_W-1:0] exp_q[$];
        logic [fx3_pkg::DATA_W-1:0] w;
        int errs;
        int cyc;
        int mism;
        errs = err_count;
        mism = 0;
        start_test(name);
        rd_count = 0;
        wr_data_q.delete();
        src_q.delete();
        for (int i = 0; i < fx3_pkg::BURST_LEN; i++) begin
            if (rnd_data) begin
                w = 16'($urandom);
            end else begin
                w = base + 16'(i);
            end
            src_q.push_back(w);
            exp_q.push_back(w);
        end
        flaga_random = rnd_flaga;
        @(negedge usb_clk);
        flagc_i = 1'b1;
        flagd_i = 1'b1;
        cyc = 0;
        while (rd_count == 0 && cyc < WAIT_CYCLES) begin
            @(negedge usb_clk);
            cyc++;
        end
        if (rd_count == 0) begin
            report_error("no read strobe after both out flags went high");
        end
        // one burst only
        flagc_i = 1'b0;
        flagd_i = 1'b0;
        cyc = 0;
        while (wr_data_q.size() < fx3_pkg::BURST_LEN && cyc < WAIT_CYCLES) begin
            @(negedge usb_clk);
            cyc++;
        end
        if (wr_data_q.size() < fx3_pkg::BURST_LEN) begin
            report_error("write burst did not complete in time");
        end
        flaga_random = 1'b0;
        repeat (4) @(negedge usb_clk);
        check("read count", 32'(fx3_pkg::BURST_LEN), 32'(rd_count));
        check("write count", 32'(fx3_pkg::BURST_LEN), 32'(wr_data_q.size()));
        for (int i = 0; i < wr_data_q.size() && i < fx3_pkg::BURST_LEN; i++) begin
            if (wr_data_q[i] !== exp_q[i] && mism < 8) begin
                check($sformatf("word %0d", i), 32'(exp_q[i]), 32'(wr_data_q[i]));
                mism++;
            end
        end
        check_idle_levels("idle");
        finish_test(errs);
    endtask

    initial begin
        void'($urandom(32'h6a90d17a));
        usb_clk      = 1'b0;
        reset_       = 1'b0;
        flaga_i      = 1'b1;
        flagc_i      = 1'b0;
        flagd_i      = 1'b0;
        fdata_i      = '0;
        rd_count     = 0;
        serve_pend1  = 1'b0;
        serve_pend2  = 1'b0;
        flaga_random = 1'b0;
        flaga_hist1  = 1'b1;
        flaga_hist2  = 1'b1;
        cur_test     = "init";
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;

        test_reset_levels();
        test_one_flag_only();
        run_burst("incrementing_loopback", 1'b0, 1'b0, 16'h0000);
        run_burst("random_with_flaga", 1'b1, 1'b1, 16'h0000);
        run_burst("back_to_back_first", 1'b0, 1'b0, 16'h8000);
        run_burst("back_to_back_second", 1'b0, 1'b0, 16'hc3a0);

        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // hard stop if the master hangs
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: simulation ran past its time limit, stopping");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== rtl/burst_counter.sv ====
`timescale 1ns/1ps

module burst_counter (
    input  logic usb_clk,
    input  logic reset_,
    input  logic inc_i,
    input  logic clear_i,
    output logic burst_last_o,
    output logic turn_done_o
);

    logic [fx3_pkg::CNT_W-1:0] count;

    // clear wins over inc
    // fsm raises both on the cycle it leaves a state
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            count <= '0;
        end else if (clear_i) begin
            count <= '0;
        end else if (inc_i) begin
            count <= count + 1'b1;
        end
    end

    // last word of the burst going out this cycle
    // qualified with inc so a stalled write does not end the burst
    assign burst_last_o = (count == fx3_pkg::LAST_WORD_CNT) && inc_i;

    // final turnaround cycle
    assign turn_done_o = (count == fx3_pkg::LAST_TURN_CNT);

endmodule

// ==== rtl/fx3_loopback_top.sv ====
`timescale 1ns/1ps

module fx3_loopback_top (
    input  logic                       usb_clk,
    input  logic                       reset_,
    input  logic                       flaga_i,
    input  logic                       flagc_i,
    input  logic                       flagd_i,
    input  logic [fx3_pkg::DATA_W-1:0] fdata_i,
    output logic [fx3_pkg::DATA_W-1:0] fdata_o,
    output logic                       fdata_oe_o,
    output logic                       slcs_n_o,
    output logic                       slrd_n_o,
    output logic                       sloe_n_o,
    output logic                       slwr_n_o,
    output logic [1:0]                 fifo_addr_o
);

    // port to fsm
    logic                       out_ready;
    logic                       in_ready;

    // fsm decisions
    logic                       rd_req;
    logic                       wr_req;
    logic                       cs;
    logic                       pop;
    logic [1:0]                 fsm_addr;

    // fsm and counter
    logic                       cnt_inc;
    logic                       cnt_clear;
    logic                       burst_last;
    logic                       turn_done;

    // fifo traffic
    logic                       push;
    logic [fx3_pkg::DATA_W-1:0] push_data;
    logic [fx3_pkg::DATA_W-1:0] head;

    fx3_master_fsm i_fsm (
        .usb_clk      (usb_clk),
        .reset_       (reset_),
        .out_ready_i  (out_ready),
        .in_ready_i   (in_ready),
        .burst_last_i (burst_last),
        .turn_done_i  (turn_done),
        .rd_req_o     (rd_req),
        .wr_req_o     (wr_req),
        .cs_o         (cs),
        .pop_o        (pop),
        .cnt_inc_o    (cnt_inc),
        .cnt_clear_o  (cnt_clear),
        .fifo_addr_o  (fsm_addr)
    );

    burst_counter i_counter (
        .usb_clk      (usb_clk),
        .reset_       (reset_),
        .inc_i        (cnt_inc),
        .clear_i      (cnt_clear),
        .burst_last_o (burst_last),
        .turn_done_o  (turn_done)
    );

    // burst sizing keeps the fifo in range, its flags stay local
    loop_fifo i_fifo (
        .usb_clk      (usb_clk),
        .reset_       (reset_),
        .push_i       (push),
        .push_data_i  (push_data),
        .pop_i        (pop),
        .head_o       (head),
        .empty_o      (),
        .full_o       ()
    );

    slave_fifo_port i_port (
        .usb_clk      (usb_clk),
        .reset_       (reset_),
        .flaga_i      (flaga_i),
        .flagc_i      (flagc_i),
        .flagd_i      (flagd_i),
        .fdata_i      (fdata_i),
        .rd_req_i     (rd_req),
        .wr_req_i     (wr_req),
        .cs_i         (cs),
        .fifo_addr_i  (fsm_addr),
        .wr_data_i    (head),
        .out_ready_o  (out_ready),
        .in_ready_o   (in_ready),
        .push_o       (push),
        .push_data_o  (push_data),
        .slcs_n_o     (slcs_n_o),
        .slrd_n_o     (slrd_n_o),
        .sloe_n_o     (sloe_n_o),
        .slwr_n_o     (slwr_n_o),
        .fifo_addr_o  (fifo_addr_o),
        .fdata_o      (fdata_o),
        .fdata_oe_o   (fdata_oe_o)
    );

endmodule

// ==== rtl/fx3_master_fsm.sv ====
`timescale 1ns/1ps

module fx3_master_fsm (
    input  logic       usb_clk,
    input  logic       reset_,
    input  logic       out_ready_i,
    input  logic       in_ready_i,
    input  logic       burst_last_i,
    input  logic       turn_done_i,
    output logic       rd_req_o,
    output logic       wr_req_o,
    output logic       cs_o,
    output logic       pop_o,
    output logic       cnt_inc_o,
    output logic       cnt_clear_o,
    output logic [1:0] fifo_addr_o
);

    fx3_pkg::master_state_t state;
    fx3_pkg::master_state_t state_nxt;

    // state register
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            state <= fx3_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            fx3_pkg::IDLE: begin
                // both out-side flags high, data waiting in fx3
                if (out_ready_i) begin
                    state_nxt = fx3_pkg::READ;
                end
            end
            fx3_pkg::READ: begin
                // last of BURST_LEN requests issued this cycle
                if (burst_last_i) begin
                    state_nxt = fx3_pkg::TURN;
                end
            end
            fx3_pkg::TURN: begin
                // fixed gap, read tail lands in the fifo here
                if (turn_done_i) begin
                    state_nxt = fx3_pkg::WRITE;
                end
            end
            fx3_pkg::WRITE: begin
                // burst_last only rises on a real pop
                if (burst_last_i) begin
                    state_nxt = fx3_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = fx3_pkg::IDLE;
            end
        endcase
    end

    // chip select held for the whole transfer
    assign cs_o = (state != fx3_pkg::IDLE);

    // one read request per cycle in READ
    assign rd_req_o = (state == fx3_pkg::READ);

    // write only while fx3 in-fifo has room
    assign wr_req_o = (state == fx3_pkg::WRITE) && in_ready_i;

    // pop and write are the same event
    assign pop_o = wr_req_o;

    // read and turnaround count every cycle, write counts pops
    assign cnt_inc_o = (state == fx3_pkg::READ) ||
                       (state == fx3_pkg::TURN) ||
                       wr_req_o;

    // fresh count for every state
    assign cnt_clear_o = (state_nxt != state);

    // socket address per direction
    always_comb begin
        case (state)
            fx3_pkg::READ: begin
                fifo_addr_o = fx3_pkg::ADDR_OUT;
            end
            fx3_pkg::WRITE: begin
                fifo_addr_o = fx3_pkg::ADDR_IN;
            end
            default: begin
                fifo_addr_o = fx3_pkg::ADDR_IDLE;
            end
        endcase
    end

endmodule

// ==== rtl/fx3_pkg.sv ====
package fx3_pkg;

    // fx3 slave fifo bus, 16-bit mode only
    localparam int DATA_W = 16;

    // words moved per burst, both directions
    localparam int BURST_LEN = 512;

    // counter wide enough for BURST_LEN-1
    localparam int CNT_W = 10;

    // idle gap between read burst and write burst
    // long enough to drain the read latency tail
    localparam int TURN_CYCLES = 10;

    // sampled slrd low to word on the bus
    localparam int READ_LATENCY = 2;

    // on-chip fifo address bits, depth is BURST_LEN
    localparam int FIFO_AW = 9;

    // counter compare values
    localparam logic [CNT_W-1:0] LAST_WORD_CNT = CNT_W'(BURST_LEN - 1);
    localparam logic [CNT_W-1:0] LAST_TURN_CNT = CNT_W'(TURN_CYCLES - 1);

    // fx3 socket addresses on A1:A0
    // out-fifo feeds us, in-fifo takes our data
    localparam logic [1:0] ADDR_OUT  = 2'b11;
    localparam logic [1:0] ADDR_IN   = 2'b00;
    localparam logic [1:0] ADDR_IDLE = 2'b10;

    // master sequencing
    typedef enum logic [1:0] {
        IDLE,
        READ,
        TURN,
        WRITE
    } master_state_t;

endpackage

// ==== rtl/loop_fifo.sv ====
`timescale 1ns/1ps

module loop_fifo (
    input  logic                      usb_clk,
    input  logic                      reset_,
    input  logic                      push_i,
    input  logic [fx3_pkg::DATA_W-1:0] push_data_i,
    input  logic                      pop_i,
    output logic [fx3_pkg::DATA_W-1:0] head_o,
    output logic                      empty_o,
    output logic                      full_o
);

    // one burst of storage
    logic [fx3_pkg::DATA_W-1:0] mem [fx3_pkg::BURST_LEN];

    // extra msb tells full from empty
    logic [fx3_pkg::FIFO_AW:0] wptr;
    logic [fx3_pkg::FIFO_AW:0] rptr;

    logic do_push;
    logic do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // storage write
    always_ff @(posedge usb_clk) begin
        if (do_push) begin
            mem[wptr[fx3_pkg::FIFO_AW-1:0]] <= push_data_i;
        end
    end

    // pointers
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    assign empty_o = (wptr == rptr);

    // same slot, other lap
    assign full_o = (wptr[fx3_pkg::FIFO_AW] != rptr[fx3_pkg::FIFO_AW]) &&
                    (wptr[fx3_pkg::FIFO_AW-1:0] == rptr[fx3_pkg::FIFO_AW-1:0]);

    // show-ahead, head valid whenever not empty
    assign head_o = mem[rptr[fx3_pkg::FIFO_AW-1:0]];

endmodule

// ==== rtl/slave_fifo_port.sv ====
`timescale 1ns/1ps

module slave_fifo_port (
    input  logic                       usb_clk,
    input  logic                       reset_,
    input  logic                       flaga_i,
    input  logic                       flagc_i,
    input  logic                       flagd_i,
    input  logic [fx3_pkg::DATA_W-1:0] fdata_i,
    input  logic                       rd_req_i,
    input  logic                       wr_req_i,
    input  logic                       cs_i,
    input  logic [1:0]                 fifo_addr_i,
    input  logic [fx3_pkg::DATA_W-1:0] wr_data_i,
    output logic                       out_ready_o,
    output logic                       in_ready_o,
    output logic                       push_o,
    output logic [fx3_pkg::DATA_W-1:0] push_data_o,
    output logic                       slcs_n_o,
    output logic                       slrd_n_o,
    output logic                       sloe_n_o,
    output logic                       slwr_n_o,
    output logic [1:0]                 fifo_addr_o,
    output logic [fx3_pkg::DATA_W-1:0] fdata_o,
    output logic                       fdata_oe_o
);

    logic flaga_q;
    logic flagc_q;
    logic flagd_q;

    // one bit per word in flight on the read side
    logic [fx3_pkg::READ_LATENCY-1:0] rd_pipe;

    // flag sampling, flags are async to our decisions
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flaga_q <= 1'b0;
            flagc_q <= 1'b0;
            flagd_q <= 1'b0;
        end else begin
            flaga_q <= flaga_i;
            flagc_q <= flagc_i;
            flagd_q <= flagd_i;
        end
    end

    // out socket has data only with both flags up
    assign out_ready_o = flagc_q & flagd_q;
    assign in_ready_o  = flaga_q;

    // pin strobes, all active low and registered
    // sloe follows slrd so the fx3 drives the bus while we read
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            slcs_n_o    <= 1'b1;
            slrd_n_o    <= 1'b1;
            sloe_n_o    <= 1'b1;
            slwr_n_o    <= 1'b1;
            fdata_oe_o  <= 1'b0;
            fifo_addr_o <= fx3_pkg::ADDR_IDLE;
            rd_pipe     <= '0;
        end else begin
            slcs_n_o    <= ~cs_i;
            slrd_n_o    <= ~rd_req_i;
            sloe_n_o    <= ~rd_req_i;
            slwr_n_o    <= ~wr_req_i;
            fdata_oe_o  <= wr_req_i;
            fifo_addr_o <= fifo_addr_i;
            // fx3 sees slrd low on this edge, word arrives READ_LATENCY edges later
            rd_pipe     <= {rd_pipe[fx3_pkg::READ_LATENCY-2:0], ~slrd_n_o};
        end
    end

    // capture read word on the edge it is valid
    assign push_o      = rd_pipe[fx3_pkg::READ_LATENCY-1];
    assign push_data_o = fdata_i;

    // write word lines up with slwr low
    always_ff @(posedge usb_clk) begin
        if (wr_req_i) begin
            fdata_o <= wr_data_i;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fx3 loopback testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_fx3_loopback \
    --Mdir obj_dir -o tb_sim \
    -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
    echo "no pass line found in sim.log"
    exit 1
fi

exit 0

// ==== sim.f ====
rtl/fx3_pkg.sv
rtl/fx3_master_fsm.sv
rtl/burst_counter.sv
rtl/loop_fifo.sv
rtl/slave_fifo_port.sv
rtl/fx3_loopback_top.sv
bench/fx3_loopback_assertions.sv
bench/tb_fx3_loopback.sv
